// ==== Makefile ====
# Verilator build and run of the datapath testbench

VERILATOR ?= verilator
TOP ?= datapath_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -j 0

SOURCES := $(wildcard design/*.sv) $(wildcard verif/*.sv)
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# Rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BINARY)
	$(BINARY) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Run reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/alu.sv ====
`timescale 1ns/1ns

module alu import datapath_pkg::*; (
    input word_t a,
    input word_t b,
    input alu_fs_t function_select,
    output word_t result,
    output flags_t flags
);

    logic [2:0] op;
    logic carry_in;
    logic invert_b;
    word_t b_add;
    logic [word_bits:0] sum;
    logic carry;
    logic overflow;
    logic negative;
    logic zero;

    assign op = function_select[4:2];
    assign carry_in = function_select[1];
    assign invert_b = function_select[0];

    // Adder operand, inverted for subtraction
    assign b_add = invert_b ? ~b : b;

    assign sum = {1'b0, a} + {1'b0, b_add} + {{word_bits{1'b0}}, carry_in};

    always_comb begin
        result = '0;
        carry = 1'b0;
        overflow = 1'b0;
        case (op)
            alu_op_add: begin
                result = sum[word_bits-1:0];
                carry = sum[word_bits];
                // Same operand signs but a different result sign
                overflow = (a[word_bits-1] == b_add[word_bits-1])
                    && (sum[word_bits-1] != a[word_bits-1]);
            end
            alu_op_and: begin
                result = a & b;
            end
            alu_op_or: begin
                result = a | b;
            end
            alu_op_xor: begin
                result = a ^ b;
            end
            alu_op_not_a: begin
                result = ~a;
            end
            alu_op_shl: begin
                // Shift amount is b modulo 64
                result = a << b[5:0];
            end
            alu_op_shr: begin
                result = a >> b[5:0];
            end
            alu_op_pass_b: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign negative = result[word_bits-1];
    assign zero = (result == '0);

    assign flags = {overflow, carry, negative, zero};

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/1ns

module data_ram import datapath_pkg::*; #(
    parameter int ram_addr_bits = 13
) (
    input logic clock,
    input logic [ram_addr_bits-1:0] address,
    input logic write,
    input word_t write_data,
    output word_t read_data
);

    localparam int depth = 1 << ram_addr_bits;

    word_t memory [depth];

    always_ff @(posedge clock) begin
        if (write) begin
            memory[address] <= write_data;
        end
    end

    // Registered read, old contents on a write to the same word
    always_ff @(posedge clock) begin
        read_data <= memory[address];
    end

endmodule

// ==== design/datapath.sv ====
`timescale 1ns/1ns

module datapath import datapath_pkg::*; #(
    parameter int ram_addr_bits = 13
) (
    input logic clock,
    input logic reset,
    input control_word_t controlword,
    input word_t immediate,
    output status_t status,
    output word_t program_count
);

    // Control word fields
    logic alu_bus_en;
    logic alu_b_select;
    alu_fs_t alu_function;
    logic reg_b_bus_en;
    logic reg_write;
    logic ram_bus_en;
    logic ram_write;
    logic pc_bus_en;
    pc_fs_t pc_function;
    logic pc_input_select;
    logic status_load;

    word_t data_bus;
    word_t alu_b;
    word_t alu_result;
    flags_t alu_flags;
    flags_t flags_q;
    word_t ram_out;
    word_t pc_in;
    word_t pc_count_next;

    regfile_if regs ();

    assign alu_bus_en = controlword[cw_alu_bus_en_bit];
    assign alu_b_select = controlword[cw_alu_b_sel_bit];
    assign alu_function = controlword[cw_alu_fs_hi:cw_alu_fs_lo];
    assign reg_b_bus_en = controlword[cw_reg_b_bus_en_bit];
    assign reg_write = controlword[cw_reg_write_bit];
    assign ram_bus_en = controlword[cw_ram_bus_en_bit];
    assign ram_write = controlword[cw_ram_write_bit];
    assign pc_bus_en = controlword[cw_pc_bus_en_bit];
    assign pc_function = controlword[cw_pc_fs_hi:cw_pc_fs_lo];
    assign pc_input_select = controlword[cw_pc_in_sel_bit];
    assign status_load = controlword[cw_status_load_bit];

    // Register file user side, written from the bus
    assign regs.select_a = controlword[cw_sel_a_hi:cw_sel_a_lo];
    assign regs.select_b = controlword[cw_sel_b_hi:cw_sel_b_lo];
    assign regs.write_address = controlword[cw_wr_addr_hi:cw_wr_addr_lo];
    assign regs.write = reg_write;
    assign regs.write_data = data_bus;

    register_file i_register_file (
        .clock(clock),
        .reset(reset),
        .regs(regs)
    );

    assign alu_b = alu_b_select ? immediate : regs.out_b;

    alu i_alu (
        .a(regs.out_a),
        .b(alu_b),
        .function_select(alu_function),
        .result(alu_result),
        .flags(alu_flags)
    );

    // ALU result is the byte address, RAM holds 64-bit words
    data_ram #(
        .ram_addr_bits(ram_addr_bits)
    ) i_data_ram (
        .clock(clock),
        .address(alu_result[ram_addr_bits+2:3]),
        .write(ram_write),
        .write_data(data_bus),
        .read_data(ram_out)
    );

    assign pc_in = pc_input_select ? regs.out_a : immediate;

    program_counter i_program_counter (
        .clock(clock),
        .reset(reset),
        .function_select(pc_function),
        .target(pc_in),
        .count(program_count),
        .count_next(pc_count_next)
    );

    // Bus priority: ALU, register B, RAM, then the link value
    always_comb begin
        if (alu_bus_en) begin
            data_bus = alu_result;
        end else if (reg_b_bus_en) begin
            data_bus = regs.out_b;
        end else if (ram_bus_en) begin
            data_bus = ram_out;
        end else if (pc_bus_en) begin
            data_bus = pc_count_next;
        end else begin
            data_bus = '0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            flags_q <= '0;
        end else if (status_load) begin
            flags_q <= alu_flags;
        end
    end

    // Low bit is the live zero flag of the current word
    assign status = {flags_q, alu_flags[0]};

endmodule

// ==== design/datapath_pkg.sv ====
package datapath_pkg;

    localparam int word_bits = 64;
    localparam int control_word_bits = 31;
    localparam int reg_count = 32;

    typedef logic [word_bits-1:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [control_word_bits-1:0] control_word_t;
    typedef logic [4:0] alu_fs_t;
    typedef logic [1:0] pc_fs_t;
    // Overflow, carry, negative, zero from the high bit down
    typedef logic [3:0] flags_t;
    typedef logic [4:0] status_t;

    // Register that always reads as zero
    localparam reg_addr_t zero_reg = 5'd31;

    // Control word fields, high end first
    localparam int cw_alu_bus_en_bit = 30;
    localparam int cw_alu_b_sel_bit = 29;
    localparam int cw_alu_fs_hi = 28;
    localparam int cw_alu_fs_lo = 24;
    localparam int cw_reg_b_bus_en_bit = 23;
    localparam int cw_sel_a_hi = 22;
    localparam int cw_sel_a_lo = 18;
    localparam int cw_sel_b_hi = 17;
    localparam int cw_sel_b_lo = 13;
    localparam int cw_wr_addr_hi = 12;
    localparam int cw_wr_addr_lo = 8;
    localparam int cw_reg_write_bit = 7;
    localparam int cw_ram_bus_en_bit = 6;
    localparam int cw_ram_write_bit = 5;
    localparam int cw_pc_bus_en_bit = 4;
    localparam int cw_pc_fs_hi = 3;
    localparam int cw_pc_fs_lo = 2;
    localparam int cw_pc_in_sel_bit = 1;
    localparam int cw_status_load_bit = 0;

    // ALU operations, function select bits 4 to 2
    localparam logic [2:0] alu_op_add = 3'b000;
    localparam logic [2:0] alu_op_and = 3'b001;
    localparam logic [2:0] alu_op_or = 3'b010;
    localparam logic [2:0] alu_op_xor = 3'b011;
    localparam logic [2:0] alu_op_not_a = 3'b100;
    localparam logic [2:0] alu_op_shl = 3'b101;
    localparam logic [2:0] alu_op_shr = 3'b110;
    localparam logic [2:0] alu_op_pass_b = 3'b111;

    // Program counter functions
    localparam pc_fs_t pc_hold = 2'd0;
    localparam pc_fs_t pc_increment = 2'd1;
    localparam pc_fs_t pc_load = 2'd2;
    localparam pc_fs_t pc_branch = 2'd3;

endpackage

// ==== design/program_counter.sv ====
`timescale 1ns/1ns

module program_counter import datapath_pkg::*; (
    input logic clock,
    input logic reset,
    input pc_fs_t function_select,
    input word_t target,
    output word_t count,
    output word_t count_next
);

    word_t branch_offset;

    // Link value and increment target
    assign count_next = count + word_t'(4);

    // Branch offset is in words
    assign branch_offset = {target[word_bits-3:0], 2'b00};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case (function_select)
                pc_hold: begin
                    count <= count;
                end
                pc_increment: begin
                    count <= count_next;
                end
                pc_load: begin
                    count <= target;
                end
                pc_branch: begin
                    count <= count + branch_offset;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// ==== design/regfile_if.sv ====
`timescale 1ns/1ns

interface regfile_if import datapath_pkg::*; ();

    reg_addr_t select_a;
    reg_addr_t select_b;
    word_t out_a;
    word_t out_b;
    reg_addr_t write_address;
    logic write;
    word_t write_data;

    // Side that drives addresses and the write port
    modport user (
        output select_a, select_b, write_address, write, write_data,
        input out_a, out_b
    );

    // Side that holds the registers
    modport owner (
        input select_a, select_b, write_address, write, write_data,
        output out_a, out_b
    );

endinterface

// ==== design/register_file.sv ====
`timescale 1ns/1ns

module register_file import datapath_pkg::*; (
    input logic clock,
    input logic reset,
    regfile_if.owner regs
);

    word_t registers [reg_count];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                registers[i] <= '0;
            end
        end else if (regs.write && regs.write_address != zero_reg) begin
            registers[regs.write_address] <= regs.write_data;
        end
    end

    // Two asynchronous read ports
    always_comb begin
        if (regs.select_a == zero_reg) begin
            regs.out_a = '0;
        end else begin
            regs.out_a = registers[regs.select_a];
        end
    end

    always_comb begin
        if (regs.select_b == zero_reg) begin
            regs.out_b = '0;
        end else begin
            regs.out_b = registers[regs.select_b];
        end
    end

endmodule

// ==== project.f ====
design/datapath_pkg.sv
design/regfile_if.sv
design/register_file.sv
design/alu.sv
design/data_ram.sv
design/program_counter.sv
design/datapath.sv
verif/datapath_tb.sv

// ==== verif/datapath_tb.sv ====
`timescale 1ns/1ns

module datapath_tb import datapath_pkg::*; ();

    localparam int ram_addr_bits = 13;
    localparam int half_period = 10;
    localparam int random_words = 2000;
    localparam int drain_timeout = 20;
    localparam logic [31:0] lfsr_seed = 32'he635_3f97;
    localparam logic [31:0] lfsr_taps = 32'ha300_0000;
    localparam alu_fs_t fs_pass_b = 5'b11100;

    logic clock;
    logic reset;
    control_word_t controlword;
    word_t immediate;
    status_t status;
    word_t program_count;

    // Reference model state
    word_t m_regs [32];
    word_t m_ram [int];
    word_t m_ram_q;
    logic m_ram_q_known;
    flags_t m_flags;
    word_t m_pc;

    logic [31:0] lfsr_state;
    status_t exp_status;
    word_t exp_pc;
    logic word_valid;
    int words_applied;
    int pc_checks;
    int mismatch_count;
    int timeout_count;

    datapath #(
        .ram_addr_bits(ram_addr_bits)
    ) i_datapath (
        .clock(clock),
        .reset(reset),
        .controlword(controlword),
        .immediate(immediate),
        .status(status),
        .program_count(program_count)
    );

    always #half_period clock = ~clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ lfsr_taps;
        end else begin
            return state >> 1;
        end
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] random_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic control_word_t build_word(
        input logic alu_en, b_sel,
        input alu_fs_t fs,
        input logic regb_en,
        input reg_addr_t sel_a, sel_b, wr_addr,
        input logic reg_wr, ram_en, ram_wr, pc_en,
        input pc_fs_t pc_fs,
        input logic pc_in_sel, st_load
    );
        return {alu_en, b_sel, fs, regb_en, sel_a, sel_b, wr_addr, reg_wr,
            ram_en, ram_wr, pc_en, pc_fs, pc_in_sel, st_load};
    endfunction

    function automatic word_t model_reg(input reg_addr_t r);
        if (r == 5'd31) begin
            return '0;
        end
        return m_regs[r];
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        m_ram.delete();
        m_ram_q = '0;
        m_ram_q_known = 1'b0;
        m_flags = '0;
        m_pc = '0;
    endfunction

    function automatic void model_step(input control_word_t cw, input word_t imm,
            output status_t st, output word_t pc_after);
        alu_fs_t fs;
        word_t a;
        word_t b;
        word_t bx;
        word_t result;
        word_t bus;
        word_t target;
        logic [64:0] sum;
        logic [63:0] low;
        logic carry;
        logic overflow;
        flags_t fl;
        int index;

        fs = cw[cw_alu_fs_hi:cw_alu_fs_lo];
        a = model_reg(cw[cw_sel_a_hi:cw_sel_a_lo]);
        b = cw[cw_alu_b_sel_bit] ? imm : model_reg(cw[cw_sel_b_hi:cw_sel_b_lo]);
        bx = fs[0] ? ~b : b;
        carry = 1'b0;
        overflow = 1'b0;
        case (fs[4:2])
            3'd0: begin
                sum = {1'b0, a} + {1'b0, bx} + {64'd0, fs[1]};
                low = {1'b0, a[62:0]} + {1'b0, bx[62:0]} + {63'd0, fs[1]};
                result = sum[63:0];
                carry = sum[64];
                // Carries into and out of the sign bit differ
                overflow = low[63] ^ sum[64];
            end
            3'd1: result = a & b;
            3'd2: result = a | b;
            3'd3: result = a ^ b;
            3'd4: result = ~a;
            3'd5: result = a << b[5:0];
            3'd6: result = a >> b[5:0];
            default: result = b;
        endcase
        fl = {overflow, carry, result[63], result == '0};
        st = {m_flags, result == '0};

        if (cw[cw_alu_bus_en_bit]) begin
            bus = result;
        end else if (cw[cw_reg_b_bus_en_bit]) begin
            bus = model_reg(cw[cw_sel_b_hi:cw_sel_b_lo]);
        end else if (cw[cw_ram_bus_en_bit]) begin
            bus = m_ram_q;
        end else if (cw[cw_pc_bus_en_bit]) begin
            bus = m_pc + 64'd4;
        end else begin
            bus = '0;
        end
        target = cw[cw_pc_in_sel_bit] ? a : imm;

        // State update at the edge that ends the cycle
        if (cw[cw_reg_write_bit] && cw[cw_wr_addr_hi:cw_wr_addr_lo] != 5'd31) begin
            m_regs[cw[cw_wr_addr_hi:cw_wr_addr_lo]] = bus;
        end
        // Registered read sees the word from before this edge's write
        index = int'(result[ram_addr_bits+2:3]);
        m_ram_q_known = m_ram.exists(index);
        if (m_ram_q_known) begin
            m_ram_q = m_ram[index];
        end
        if (cw[cw_ram_write_bit]) begin
            m_ram[index] = bus;
        end
        if (cw[cw_status_load_bit]) begin
            m_flags = fl;
        end
        case (cw[cw_pc_fs_hi:cw_pc_fs_lo])
            pc_increment: m_pc = m_pc + 64'd4;
            pc_load: m_pc = target;
            pc_branch: m_pc = m_pc + target * 64'd4;
            default: m_pc = m_pc;
        endcase
        pc_after = m_pc;
    endfunction

    task automatic apply_word(input control_word_t cw, input word_t imm);
        @(negedge clock);
        controlword = cw;
        immediate = imm;
        model_step(cw, imm, exp_status, exp_pc);
        word_valid = 1'b1;
        words_applied++;
    endtask

    task automatic load_reg(input reg_addr_t rd, input word_t value);
        apply_word(build_word(1'b1, 1'b1, fs_pass_b, 1'b0, 5'd31, 5'd31, rd,
            1'b1, 1'b0, 1'b0, 1'b0, pc_hold, 1'b0, 1'b0), value);
    endtask

    // Register value shows up on program_count
    task automatic expose_reg(input reg_addr_t ra);
        apply_word(build_word(1'b0, 1'b0, 5'd0, 1'b0, ra, 5'd31, 5'd0,
            1'b0, 1'b0, 1'b0, 1'b0, pc_load, 1'b1, 1'b0), '0);
    endtask

    task automatic run_alu(input alu_fs_t fs, input reg_addr_t ra, rb, rd);
        apply_word(build_word(1'b1, 1'b0, fs, 1'b0, ra, rb, rd,
            1'b1, 1'b0, 1'b0, 1'b0, pc_hold, 1'b0, 1'b1), random_bits(64));
    endtask

    task automatic verify_reset_state();
        if (program_count !== '0) begin
            mismatch_count++;
            $display("mismatch at %0t ns: program_count %h after reset", $time, program_count);
        end
        if (status[4:1] !== 4'b0000) begin
            mismatch_count++;
            $display("mismatch at %0t ns: flags %b after reset", $time, status[4:1]);
        end
    endtask

    task automatic exercise_alu();
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            load_reg(reg_addr_t'(i), random_bits(64));
        end
        // Every function code, carry-in and invert included
        for (int op = 0; op < 32; op++) begin
            r = random_bits(9);
            run_alu(alu_fs_t'(op), {2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]});
            expose_reg({2'b00, r[8:6]});
        end
        load_reg(5'd1, 64'h8000_0000_0000_0000);
        load_reg(5'd2, 64'd1);
        run_alu(5'b00011, 5'd1, 5'd2, 5'd3);
        expose_reg(5'd3);
        run_alu(5'b00000, 5'd1, 5'd1, 5'd4);
        run_alu(5'b00011, 5'd2, 5'd2, 5'd5);
        run_alu(5'b00011, 5'd2, 5'd1, 5'd6);
        expose_reg(5'd6);
    endtask

    task automatic zero_register_writes();
        load_reg(5'd31, random_bits(64));
        expose_reg(5'd31);
        run_alu(5'b01000, 5'd31, 5'd31, 5'd7);
        expose_reg(5'd7);
    endtask

    task automatic store_and_load();
        word_t addr;
        repeat (8) begin
            addr = random_bits(64);
            load_reg(5'd4, random_bits(64));
            // Address from the immediate, data from register b
            apply_word(build_word(1'b0, 1'b1, fs_pass_b, 1'b1, 5'd31, 5'd4, 5'd0,
                1'b0, 1'b0, 1'b1, 1'b0, pc_hold, 1'b0, 1'b0), addr);
            apply_word(build_word(1'b0, 1'b1, fs_pass_b, 1'b0, 5'd31, 5'd31, 5'd0,
                1'b0, 1'b0, 1'b0, 1'b0, pc_hold, 1'b0, 1'b0), addr);
            apply_word(build_word(1'b0, 1'b1, fs_pass_b, 1'b0, 5'd31, 5'd31, 5'd5,
                1'b1, 1'b1, 1'b0, 1'b0, pc_hold, 1'b0, 1'b0), addr);
            expose_reg(5'd5);
        end
    endtask

    task automatic walk_program_counter();
        logic [63:0] r;
        repeat (3) begin
            apply_word(build_word(1'b0, 1'b0, 5'd0, 1'b0, 5'd31, 5'd31, 5'd0,
                1'b0, 1'b0, 1'b0, 1'b0, pc_increment, 1'b0, 1'b0), '0);
        end
        repeat (2) begin
            apply_word('0, '0);
        end
        repeat (6) begin
            r = random_bits(8);
            apply_word(build_word(1'b0, 1'b0, 5'd0, 1'b0, 5'd31, 5'd31, 5'd0,
                1'b0, 1'b0, 1'b0, 1'b0, pc_branch, 1'b0, 1'b0), {{56{r[7]}}, r[7:0]});
        end
        apply_word(build_word(1'b0, 1'b0, 5'd0, 1'b0, 5'd31, 5'd31, 5'd0,
            1'b0, 1'b0, 1'b0, 1'b0, pc_load, 1'b0, 1'b0), random_bits(64));
        // Link value is the count plus 4
        apply_word(build_word(1'b0, 1'b0, 5'd0, 1'b0, 5'd31, 5'd31, 5'd6,
            1'b1, 1'b0, 1'b0, 1'b1, pc_increment, 1'b0, 1'b0), '0);
        expose_reg(5'd6);
    endtask

    task automatic run_random_words();
        logic [63:0] r;
        control_word_t cw;
        for (int i = 0; i < random_words; i++) begin
            r = random_bits(31);
            cw = r[30:0];
            // RAM drives the bus only when its output word is known
            if (cw[cw_ram_bus_en_bit] && !cw[cw_alu_bus_en_bit] && !cw[cw_reg_b_bus_en_bit]
                    && !m_ram_q_known) begin
                cw[cw_ram_bus_en_bit] = 1'b0;
            end
            apply_word(cw, random_bits(64));
        end
    endtask

    task automatic wait_for_checks();
        int waited;
        waited = 0;
        while (pc_checks != words_applied && waited < drain_timeout) begin
            @(posedge clock);
            #3;
            waited++;
        end
        if (pc_checks != words_applied) begin
            timeout_count++;
            $display("Timed out waiting for the last control words to be checked");
        end
    endtask

    // Status once inputs settle, program count after the edge
    always begin
        @(negedge clock);
        #2;
        if (word_valid && status !== exp_status) begin
            mismatch_count++;
            $display("mismatch at %0t ns: status %b, expected %b", $time, status, exp_status);
        end
        @(posedge clock);
        #2;
        if (word_valid) begin
            if (program_count !== exp_pc) begin
                mismatch_count++;
                $display("mismatch at %0t ns: program_count %h, expected %h",
                    $time, program_count, exp_pc);
            end
            pc_checks++;
            word_valid = 1'b0;
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        controlword = '0;
        immediate = '0;
        word_valid = 1'b0;
        words_applied = 0;
        pc_checks = 0;
        mismatch_count = 0;
        timeout_count = 0;
        lfsr_state = lfsr_seed;
        model_reset();
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        verify_reset_state();
        repeat (4) begin
            apply_word('0, '0);
        end
        exercise_alu();
        zero_register_writes();
        store_and_load();
        walk_program_counter();
        run_random_words();
        wait_for_checks();
        $display("Errors: %0d mismatches, %0d timeouts, %0d words checked",
            mismatch_count, timeout_count, pc_checks);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
